/* Bender.yml */
package:
  name: rx_ring

export_include_dirs:
  - src

sources:
  - src/rx_ring_pkg.sv
  - src/rx_block_writer.sv
  - src/rx_dma_reader.sv
  - src/rx_ring_mem.sv
  - src/rx_ring_regs.sv
  - src/rx_ring_top.sv
  - target: test
    files:
      - verification/rx_ring_props.sv
      - verification/rx_ring_tb.sv

/* sources.f */
+incdir+src
src/rx_ring_pkg.sv
src/rx_block_writer.sv
src/rx_dma_reader.sv
src/rx_ring_mem.sv
src/rx_ring_regs.sv
src/rx_ring_top.sv
verification/rx_ring_props.sv
verification/rx_ring_tb.sv

/* src/rx_block_writer.sv */
`timescale 1ns/1ps
`include "rx_ring_consts.svh"

module rx_block_writer (
   input  logic                  clock,
   input  logic                  rst_n,
   input  rx_ring_pkg::block_t   data_in,
   input  logic                  wrreq,
   input  logic                  enable,
   input  rx_ring_pkg::ptr_t     rptr,
   input  logic                  drops_clear,
   output rx_ring_pkg::ptr_t     wptr,
   output logic [`RX_DROP_W-1:0] drops,
   output logic                  wr_req,
   output rx_ring_pkg::slot_t    wr_slot,
   output rx_ring_pkg::block_t   wr_data
);

   // Blocks currently held in the ring
   logic [`RX_PTR_W-1:0] used;
   logic                 full;
   logic                 accept;
   logic                 drop;

   // Occupancy from the pointer difference, wrap bit included
   assign used = wptr - rptr;
   // Full at exactly one ring depth, wrap bit set and slot bits clear
   assign full = (used == {1'b1, {`RX_SLOT_W{1'b0}}});

   // Gearbox block admitted only with room left
   assign accept = wrreq && enable && !full;
   // Valid block with no room, lost and counted
   assign drop = wrreq && enable && full;

   // ----------------------------------------------------------
   // Write pointer and drop counter
   // ----------------------------------------------------------

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         wptr  <= '0;
         drops <= '0;
      end else begin
         // Pointer moves on the admit edge, memory write follows
         if (accept) begin
            wptr <= wptr + 1'b1;
         end
         // Software clear wins over a drop on the same edge
         if (drops_clear) begin
            drops <= '0;
         end else if (drop && (drops != '1)) begin
            drops <= drops + 1'b1;
         end
      end
   end

   // ----------------------------------------------------------
   // One-entry write stage toward the ring memory
   // ----------------------------------------------------------

   // Request flag, memory writes it on the next edge
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         wr_req <= 1'b0;
      end else begin
         wr_req <= accept;
      end
   end

   // Slot and block captured with the admit
   always_ff @(posedge clock) begin
      if (accept) begin
         wr_slot <= wptr[`RX_SLOT_W-1:0];
         wr_data <= data_in;
      end
   end

endmodule

/* src/rx_dma_reader.sv */
`timescale 1ns/1ps
`include "rx_ring_consts.svh"

module rx_dma_reader (
   input  logic                clock,
   input  logic                rst_n,
   input  logic                rdreq,
   input  rx_ring_pkg::slot_t  rd_address,
   input  logic                enable,
   input  rx_ring_pkg::ptr_t   rptr,
   input  rx_ring_pkg::ptr_t   wptr,
   input  logic                rd_gnt,
   input  rx_ring_pkg::block_t rd_data,
   output logic                rd_ready,
   output logic                rd_req,
   output rx_ring_pkg::slot_t  rd_slot,
   output rx_ring_pkg::block_t data_out,
   output logic                rd_valid,
   output logic                rd_error
);

   // Idle, waiting for the memory grant, response cycle
   typedef enum logic [1:0] {
      S_IDLE,
      S_WAIT,
      S_DONE
   } state_t;

   state_t               state;
   logic [`RX_PTR_W-1:0] used;
   rx_ring_pkg::slot_t   offset;
   logic                 occupied;
   logic                 take;
   logic                 good;

   // ----------------------------------------------------------
   // Occupancy check on the requested slot
   // ----------------------------------------------------------

   // Blocks between read and write pointer
   assign used = wptr - rptr;
   // Distance of the slot from the oldest block, modulo depth
   assign offset = rd_address - rptr[`RX_SLOT_W-1:0];
   // Slot holds data when it lies inside the used window
   assign occupied = ({1'b0, offset} < used);

   assign take = rdreq && rd_ready;
   assign good = enable && occupied;

   // Handshake outputs straight from the state
   assign rd_ready = (state == S_IDLE);
   assign rd_req   = (state == S_WAIT);
   assign rd_valid = (state == S_DONE);
   // Memory data lands with rd_valid, refused reads return zero
   assign data_out = (rd_valid && !rd_error) ? rd_data : '0;

   // ----------------------------------------------------------
   // Request FSM, one read in flight
   // ----------------------------------------------------------

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         state    <= S_IDLE;
         rd_error <= 1'b0;
      end else begin
         case (state)
            S_IDLE: begin
               if (take) begin
                  // Bad slot skips the memory, answers next cycle
                  rd_error <= !good;
                  state    <= good ? S_WAIT : S_DONE;
               end
            end
            S_WAIT: begin
               // Held here while the writer owns the port
               if (rd_gnt) begin
                  state <= S_DONE;
               end
            end
            default: begin
               rd_error <= 1'b0;
               state    <= S_IDLE;
            end
         endcase
      end
   end

   // Slot latched with the request
   always_ff @(posedge clock) begin
      if (take) begin
         rd_slot <= rd_address;
      end
   end

endmodule

/* src/rx_ring_consts.svh */
`ifndef RX_RING_CONSTS_SVH
`define RX_RING_CONSTS_SVH

// ----------------------------------------------------------
// Ring geometry
// ----------------------------------------------------------

// Number of block slots in the receive ring
`define RX_RING_DEPTH 16
// Slot address width, log2 of the depth
`define RX_SLOT_W 4
// Pointer width, slot address plus one wrap bit
`define RX_PTR_W 5
// One 66b block, sync header and payload
`define RX_BLOCK_W 66

// ----------------------------------------------------------
// APB register map, byte offsets
// ----------------------------------------------------------

// Control, bit 0 enables the ring
`define RX_REG_CTRL 8'h00
// Software read pointer
`define RX_REG_RPTR 8'h04
// Hardware write pointer, read only
`define RX_REG_WPTR 8'h08
// Full, empty and occupancy
`define RX_REG_STATUS 8'h0C
// Dropped block count, write clears
`define RX_REG_DROPS 8'h10

// Saturating drop counter width
`define RX_DROP_W 16

`endif

/* src/rx_ring_mem.sv */
`timescale 1ns/1ps
`include "rx_ring_consts.svh"

module rx_ring_mem (
   input  logic                clock,
   input  logic                rst_n,
   input  logic                wr_req,
   input  rx_ring_pkg::slot_t  wr_slot,
   input  rx_ring_pkg::block_t wr_data,
   input  logic                rd_req,
   input  rx_ring_pkg::slot_t  rd_slot,
   output logic                rd_gnt,
   output rx_ring_pkg::block_t rd_data
);

   // ----------------------------------------------------------
   // Single-port block store
   // ----------------------------------------------------------

   rx_ring_pkg::block_t ring [`RX_RING_DEPTH];

   // Fixed priority, a staged write always takes the port
   // Reads only when the writer is idle this cycle
   assign rd_gnt = rd_req && !wr_req;

   // Write lands on the edge it is presented
   always_ff @(posedge clock) begin
      if (wr_req) begin
         ring[wr_slot] <= wr_data;
      end
   end

   // ----------------------------------------------------------
   // Read return register
   // ----------------------------------------------------------

   // Addressed block registered on the grant edge
   // Valid in the cycle after the grant
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         rd_data <= '0;
      end else if (rd_gnt) begin
         rd_data <= ring[rd_slot];
      end
   end

endmodule

/* src/rx_ring_pkg.sv */
`include "rx_ring_consts.svh"

package rx_ring_pkg;

   // ----------------------------------------------------------
   // Ring data and pointer types
   // ----------------------------------------------------------

   // One block as delivered by the gearbox
   // Bits 65:64 carry the sync header
   // Bits 63:0 carry the scrambled payload
   typedef logic [`RX_BLOCK_W-1:0] block_t;

   // Ring pointer with one wrap bit on top
   // Equal pointers mean empty
   // Same slot with different wrap bits means full
   typedef logic [`RX_PTR_W-1:0] ptr_t;

   // Absolute slot address into the ring memory
   // Lower bits of a pointer
   typedef logic [`RX_SLOT_W-1:0] slot_t;

endpackage

/* src/rx_ring_regs.sv */
`timescale 1ns/1ps
`include "rx_ring_consts.svh"

module rx_ring_regs (
   input  logic                  clock,
   input  logic                  rst_n,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [7:0]            paddr,
   input  logic [31:0]           pwdata,
   input  rx_ring_pkg::ptr_t     wptr,
   input  logic [`RX_DROP_W-1:0] drops,
   output logic [31:0]           prdata,
   output logic                  pready,
   output logic                  pslverr,
   output logic                  enable,
   output rx_ring_pkg::ptr_t     rptr,
   output logic                  drops_clear
);

   logic                 access;
   logic                 wr_access;
   logic                 ctrl_hit;
   logic                 rptr_hit;
   logic                 wptr_hit;
   logic                 status_hit;
   logic                 drops_hit;
   logic                 known;
   logic                 ro_write;
   logic [`RX_PTR_W-1:0] used;
   logic                 full;
   logic                 empty;
   logic [31:0]          status_word;

   // ----------------------------------------------------------
   // APB decode
   // ----------------------------------------------------------

   // Access phase, no wait states
   assign access    = psel && penable;
   assign wr_access = access && pwrite;
   assign pready    = 1'b1;

   assign ctrl_hit   = (paddr == `RX_REG_CTRL);
   assign rptr_hit   = (paddr == `RX_REG_RPTR);
   assign wptr_hit   = (paddr == `RX_REG_WPTR);
   assign status_hit = (paddr == `RX_REG_STATUS);
   assign drops_hit  = (paddr == `RX_REG_DROPS);

   assign known = ctrl_hit || rptr_hit || wptr_hit || status_hit || drops_hit;
   // DROPS accepts a write as its clear strobe
   assign ro_write = pwrite && (wptr_hit || status_hit);
   // Error only inside the access phase
   assign pslverr = access && (!known || ro_write);

   // Clear pulse lines up with the access-phase edge
   assign drops_clear = wr_access && drops_hit;

   // ----------------------------------------------------------
   // Status from the pointer difference
   // ----------------------------------------------------------

   assign used  = wptr - rptr;
   assign full  = (used == {1'b1, {`RX_SLOT_W{1'b0}}});
   assign empty = (used == '0);
   // Occupancy from bit 8, flags in bits 1:0
   assign status_word = {{(24 - `RX_PTR_W){1'b0}}, used, 6'b0, empty, full};

   // Read mux
   always_comb begin
      case (paddr)
         `RX_REG_CTRL:   prdata = {31'b0, enable};
         `RX_REG_RPTR:   prdata = {{(32 - `RX_PTR_W){1'b0}}, rptr};
         `RX_REG_WPTR:   prdata = {{(32 - `RX_PTR_W){1'b0}}, wptr};
         `RX_REG_STATUS: prdata = status_word;
         `RX_REG_DROPS:  prdata = {{(32 - `RX_DROP_W){1'b0}}, drops};
         default:        prdata = '0;
      endcase
   end

   // ----------------------------------------------------------
   // Writable registers
   // ----------------------------------------------------------

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         enable <= 1'b0;
         rptr   <= '0;
      end else if (wr_access) begin
         if (ctrl_hit) begin
            enable <= pwdata[0];
         end
         // Software frees slots by moving the read pointer
         if (rptr_hit) begin
            rptr <= pwdata[`RX_PTR_W-1:0];
         end
      end
   end

endmodule

/* src/rx_ring_top.sv */
`timescale 1ns/1ps
`include "rx_ring_consts.svh"

module rx_ring_top (
   input  logic                clock,
   input  logic                rst_n,
   // Gearbox side
   input  rx_ring_pkg::block_t data_in,
   input  logic                wrreq,
   // DMA side
   input  logic                rdreq,
   input  rx_ring_pkg::slot_t  rd_address,
   output logic                rd_ready,
   output rx_ring_pkg::block_t data_out,
   output logic                rd_valid,
   output logic                rd_error,
   // APB control and status
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  logic [7:0]          paddr,
   input  logic [31:0]         pwdata,
   output logic [31:0]         prdata,
   output logic                pready,
   output logic                pslverr,
   // Write pointer export for the interrupt block
   output rx_ring_pkg::ptr_t   rx_ring_wptr
);

   // ----------------------------------------------------------
   // Internal wiring
   // ----------------------------------------------------------

   rx_ring_pkg::ptr_t     wptr;
   rx_ring_pkg::ptr_t     rptr;
   logic [`RX_DROP_W-1:0] drops;
   logic                  enable;
   logic                  drops_clear;
   // Writer to memory
   logic                  wr_req;
   rx_ring_pkg::slot_t    wr_slot;
   rx_ring_pkg::block_t   wr_data;
   // Reader to memory and back
   logic                  rd_req;
   rx_ring_pkg::slot_t    rd_slot;
   logic                  rd_gnt;
   rx_ring_pkg::block_t   rd_data;

   assign rx_ring_wptr = wptr;

   rx_block_writer u_writer (
      .clock       (clock),
      .rst_n       (rst_n),
      .data_in     (data_in),
      .wrreq       (wrreq),
      .enable      (enable),
      .rptr        (rptr),
      .drops_clear (drops_clear),
      .wptr        (wptr),
      .drops       (drops),
      .wr_req      (wr_req),
      .wr_slot     (wr_slot),
      .wr_data     (wr_data)
   );

   rx_dma_reader u_reader (
      .clock      (clock),
      .rst_n      (rst_n),
      .rdreq      (rdreq),
      .rd_address (rd_address),
      .enable     (enable),
      .rptr       (rptr),
      .wptr       (wptr),
      .rd_gnt     (rd_gnt),
      .rd_data    (rd_data),
      .rd_ready   (rd_ready),
      .rd_req     (rd_req),
      .rd_slot    (rd_slot),
      .data_out   (data_out),
      .rd_valid   (rd_valid),
      .rd_error   (rd_error)
   );

   // Shared single port, writer first
   rx_ring_mem u_mem (
      .clock   (clock),
      .rst_n   (rst_n),
      .wr_req  (wr_req),
      .wr_slot (wr_slot),
      .wr_data (wr_data),
      .rd_req  (rd_req),
      .rd_slot (rd_slot),
      .rd_gnt  (rd_gnt),
      .rd_data (rd_data)
   );

   rx_ring_regs u_regs (
      .clock       (clock),
      .rst_n       (rst_n),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .wptr        (wptr),
      .drops       (drops),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .enable      (enable),
      .rptr        (rptr),
      .drops_clear (drops_clear)
   );

endmodule

/* verification/rx_ring_props.sv */
`timescale 1ns/1ps
`include "rx_ring_consts.svh"

module rx_ring_props (
   input logic              clock,
   input logic              rst_n,
   input rx_ring_pkg::ptr_t wptr,
   input rx_ring_pkg::ptr_t rptr,
   input logic              rd_ready,
   input logic              rd_valid,
   input logic              psel,
   input logic              penable,
   input logic              pslverr
);

   // Blocks held from the pointer difference
   rx_ring_pkg::ptr_t used;
   // Count of failed assertions
   int                fail_count = 0;

   assign used = wptr - rptr;

   // ----------------------------------------------------------
   // Ring and handshake properties
   // ----------------------------------------------------------

   // Never more blocks than slots
   occupancy_bound: assert property (@(posedge clock) disable iff (!rst_n)
      used <= `RX_RING_DEPTH)
      else begin
         fail_count++;
         $error("ring occupancy %0d above depth", used);
      end

   // Response only while the reader is busy
   valid_not_ready: assert property (@(posedge clock) disable iff (!rst_n)
      !(rd_valid && rd_ready))
      else begin
         fail_count++;
         $error("rd_valid high together with rd_ready");
      end

   // Slave error confined to the APB access phase
   slverr_in_access: assert property (@(posedge clock) disable iff (!rst_n)
      pslverr |-> (psel && penable))
      else begin
         fail_count++;
         $error("pslverr outside an access phase");
      end

endmodule

/* verification/rx_ring_tb.sv */
`timescale 1ns/1ps
`include "rx_ring_consts.svh"

module rx_ring_tb;

   // Cycle budgets per test and a run limit of twice their sum
   localparam int RESET_CYC    = 60;
   localparam int DISABLE_CYC  = 120;
   localparam int STREAM_OPS   = 240;
   localparam int STREAM_CYC   = STREAM_OPS * 24;
   localparam int OVERFLOW_CYC = 200;
   localparam int REFUSE_CYC   = 80;
   localparam int SLVERR_CYC   = 80;
   localparam int LIMIT_CYC    = 2 * (5 + RESET_CYC + DISABLE_CYC + STREAM_CYC
                                      + OVERFLOW_CYC + REFUSE_CYC + SLVERR_CYC);

   logic                clock;
   logic                rst_n;
   rx_ring_pkg::block_t data_in;
   logic                wrreq;
   logic                rdreq;
   rx_ring_pkg::slot_t  rd_address;
   logic                rd_ready;
   rx_ring_pkg::block_t data_out;
   logic                rd_valid;
   logic                rd_error;
   logic                psel;
   logic                penable;
   logic                pwrite;
   logic [7:0]          paddr;
   logic [31:0]         pwdata;
   logic [31:0]         prdata;
   logic                pready;
   logic                pslverr;
   rx_ring_pkg::ptr_t   rx_ring_wptr;

   // Reference model of the ring
   rx_ring_pkg::block_t ring_q[$];
   rx_ring_pkg::ptr_t   m_wptr;
   rx_ring_pkg::ptr_t   m_rptr;
   logic [15:0]         m_drops;
   logic                m_enable;

   logic [31:0] rng = 32'd16603;
   int          cycles = 0;
   int          errors = 0;
   int          test_errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   string       test_name;

   rx_ring_top DUT (.*);

   bind rx_ring_top rx_ring_props u_props (
      .clock    (clock),
      .rst_n    (rst_n),
      .wptr     (wptr),
      .rptr     (rptr),
      .rd_ready (rd_ready),
      .rd_valid (rd_valid),
      .psel     (psel),
      .penable  (penable),
      .pslverr  (pslverr)
   );

   // 4 ns period
   always #2 clock = ~clock;

   // Run limit
   always @(posedge clock) begin
      cycles <= cycles + 1;
      if (cycles == LIMIT_CYC) begin
         $display("Timeout: run stopped after %0d cycles with tests unfinished", LIMIT_CYC);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // ----------------------------------------------------------
   // Random stimulus
   // ----------------------------------------------------------

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // Legal sync header 01 or 10 over a random payload
   function automatic rx_ring_pkg::block_t rand_block();
      logic [31:0] hdr;
      hdr = next_rand();
      return {hdr[0], ~hdr[0], next_rand(), next_rand()};
   endfunction

   // ----------------------------------------------------------
   // Reporting
   // ----------------------------------------------------------

   task automatic report_mismatch(input string what, input logic [65:0] expected,
                                  input logic [65:0] actual);
      $display("ERROR %s %s: expected %h actual %h", test_name, what, expected, actual);
      test_errors++;
   endtask

   task automatic finish_test();
      tests_run++;
      if (test_errors == 0) begin
         $display("test %s: ok", test_name);
      end else begin
         $display("test %s: %0d errors", test_name, test_errors);
         tests_failed++;
      end
      errors += test_errors;
      test_errors = 0;
   endtask

   // ----------------------------------------------------------
   // Bus tasks start and end on a falling edge
   // ----------------------------------------------------------

   // Setup phase then access phase sampled in the low half of the clock
   task automatic apb_access(input logic write, input logic [7:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
      psel = 1'b1;
      penable = 1'b0;
      pwrite = write;
      paddr = addr;
      pwdata = wdata;
      @(negedge clock);
      penable = 1'b1;
      #1;
      rdata = prdata;
      err = pslverr;
      // No wait states in any access
      if (pready !== 1'b1) begin
         report_mismatch("pready", 1'b1, pready);
      end
      @(negedge clock);
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
      logic [31:0] rdata;
      logic        err;
      apb_access(1'b1, addr, wdata, rdata, err);
      if (err) begin
         $display("ERROR %s: APB write to offset %h was refused with pslverr", test_name, addr);
         test_errors++;
      end
   endtask

   task automatic check_reg(input string what, input logic [7:0] addr,
                            input logic [31:0] expected);
      logic [31:0] value;
      logic        err;
      apb_access(1'b0, addr, 32'h0, value, err);
      if (err) begin
         $display("ERROR %s: APB read of %s was refused with pslverr", test_name, what);
         test_errors++;
      end
      if (value !== expected) begin
         report_mismatch(what, expected, value);
      end
   endtask

   // Pointers and drop count against the model
   task automatic check_regs();
      check_reg("WPTR", `RX_REG_WPTR, {27'b0, m_wptr});
      check_reg("RPTR", `RX_REG_RPTR, {27'b0, m_rptr});
      check_reg("DROPS", `RX_REG_DROPS, {16'b0, m_drops});
      if (rx_ring_wptr !== m_wptr) begin
         report_mismatch("rx_ring_wptr", m_wptr, rx_ring_wptr);
      end
   endtask

   // One gearbox block with the model following the admit rule
   task automatic push_block(input int gap);
      rx_ring_pkg::block_t blk;
      blk = rand_block();
      data_in = blk;
      wrreq = 1'b1;
      @(negedge clock);
      wrreq = 1'b0;
      if (m_enable && ring_q.size() < `RX_RING_DEPTH) begin
         ring_q.push_back(blk);
         m_wptr = m_wptr + 1'b1;
      end else if (m_enable) begin
         m_drops = m_drops + 1'b1;
      end
      repeat (gap) @(negedge clock);
   endtask

   // DMA request completed by the rd_valid pulse
   task automatic dma_read(input rx_ring_pkg::slot_t slot, output rx_ring_pkg::block_t data,
                           output logic err);
      while (!rd_ready) @(negedge clock);
      rdreq = 1'b1;
      rd_address = slot;
      @(negedge clock);
      rdreq = 1'b0;
      while (!rd_valid) @(negedge clock);
      data = data_out;
      err = rd_error;
      @(negedge clock);
   endtask

   // ----------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------

   initial begin
      rx_ring_pkg::block_t data;
      rx_ring_pkg::slot_t  slot;
      logic                err;
      logic [31:0]         r;
      logic [31:0]         rdata;
      int                  extra;
      int                  idx;

      clock = 1'b0;
      rst_n = 1'b0;
      data_in = '0;
      wrreq = 1'b0;
      rdreq = 1'b0;
      rd_address = '0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      m_wptr = '0;
      m_rptr = '0;
      m_drops = '0;
      m_enable = 1'b0;
      repeat (5) @(negedge clock);
      rst_n = 1'b1;

      test_name = "reset_values";
      check_reg("CTRL", `RX_REG_CTRL, 32'h0);
      // Empty flag with zero occupancy
      check_reg("STATUS", `RX_REG_STATUS, 32'h2);
      check_regs();
      apb_write(`RX_REG_CTRL, 32'h1);
      check_reg("CTRL", `RX_REG_CTRL, 32'h1);
      finish_test();

      test_name = "disabled";
      apb_write(`RX_REG_CTRL, 32'h0);
      repeat (20) push_block(next_rand() % 2);
      check_regs();
      finish_test();

      // Random mix of arrivals and DMA reads of the oldest block
      test_name = "stream";
      apb_write(`RX_REG_CTRL, 32'h1);
      m_enable = 1'b1;
      repeat (STREAM_OPS) begin
         r = next_rand();
         if (ring_q.size() < `RX_RING_DEPTH && (r[0] || ring_q.size() == 0)) begin
            push_block(r[3:1]);
         end else begin
            dma_read(m_rptr[`RX_SLOT_W-1:0], data, err);
            if (err !== 1'b0) begin
               report_mismatch("rd_error", 1'b0, err);
            end
            if (data !== ring_q[0]) begin
               report_mismatch("data_out", ring_q[0], data);
            end
            ring_q.delete(0);
            m_rptr = m_rptr + 1'b1;
            apb_write(`RX_REG_RPTR, {27'b0, m_rptr});
         end
      end
      check_regs();
      finish_test();

      test_name = "overflow";
      // Free the whole ring first
      m_rptr = m_wptr;
      ring_q.delete();
      apb_write(`RX_REG_RPTR, {27'b0, m_rptr});
      extra = 3 + next_rand() % 8;
      repeat (`RX_RING_DEPTH + extra) push_block(0);
      // Occupancy 16 at bit 8 with the full flag
      check_reg("STATUS", `RX_REG_STATUS, 32'h1001);
      // Every block past the sixteenth is lost
      check_reg("DROPS", `RX_REG_DROPS, extra);
      check_regs();
      apb_write(`RX_REG_DROPS, 32'h0);
      m_drops = '0;
      check_reg("DROPS", `RX_REG_DROPS, 32'h0);
      finish_test();

      // Four occupied slots left after the read pointer
      test_name = "refused_read";
      m_rptr = m_rptr + 5'd12;
      repeat (12) ring_q.delete(0);
      apb_write(`RX_REG_RPTR, {27'b0, m_rptr});
      r = next_rand();
      slot = rx_ring_pkg::slot_t'(m_rptr + 5'd4 + (r % 12));
      dma_read(slot, data, err);
      if (err !== 1'b1) begin
         report_mismatch("rd_error", 1'b1, err);
      end
      if (data !== '0) begin
         report_mismatch("data_out", '0, data);
      end
      idx = r % 4;
      slot = rx_ring_pkg::slot_t'(m_rptr + idx);
      dma_read(slot, data, err);
      if (err !== 1'b0) begin
         report_mismatch("rd_error", 1'b0, err);
      end
      if (data !== ring_q[idx]) begin
         report_mismatch("data_out", ring_q[idx], data);
      end
      finish_test();

      // Write data keeps bit 0 clear so a stray CTRL write shows up
      test_name = "slave_error";
      apb_access(1'b0, 8'h14, 32'h0, rdata, err);
      if (err !== 1'b1) begin
         report_mismatch("pslverr unknown read", 1'b1, err);
      end
      apb_access(1'b1, 8'h20, next_rand() & 32'hFFFF_FFFE, rdata, err);
      if (err !== 1'b1) begin
         report_mismatch("pslverr unknown write", 1'b1, err);
      end
      apb_access(1'b1, `RX_REG_WPTR, next_rand() & 32'hFFFF_FFFE, rdata, err);
      if (err !== 1'b1) begin
         report_mismatch("pslverr WPTR write", 1'b1, err);
      end
      check_reg("CTRL", `RX_REG_CTRL, 32'h1);
      check_regs();
      finish_test();

      // Failures of the bound assertions count against the run
      if (DUT.u_props.fail_count != 0) begin
         $display("Bound assertions failed %0d times", DUT.u_props.fail_count);
         errors += DUT.u_props.fail_count;
      end

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule
